// File: fdsu_ctrl_sva.sv
`default_nettype none

module fdsu_ctrl_sva (
  input wire logic fdsu_clk,
  input wire logic cpurst_b,
  input wire logic flush,
  input wire logic wb_grnt,
  input wire logic wb_req,
  input wire logic ex1_pipedown,
  input wire logic ex2_pipedown,
  input wire logic ex3_pipedown,
  input wire logic ex4_pipedown,
  input wire logic ex2_srt_first_round,
  input wire logic srt_sm_on,
  input wire logic ex1_denormal_stall,
  input wire logic busy,
  input wire logic state_idle
);

  // ====================================================================
  // write-back handshake
  // ====================================================================
  // request held until the grant
  a_wb_hold: assert property (@(posedge fdsu_clk) disable iff (!cpurst_b)
    wb_req && !wb_grnt && !flush |=> wb_req)
    else $error("wb_req dropped without wb_grnt");

  // ====================================================================
  // pipedown strobes
  // ====================================================================
  // one stage at a time
  a_pipe_excl: assert property (@(posedge fdsu_clk) disable iff (!cpurst_b)
    $onehot0({ex1_pipedown, ex2_pipedown, ex3_pipedown, ex4_pipedown}))
    else $error("more than one pipedown strobe high");

  a_first_set: assert property (@(posedge fdsu_clk) disable iff (!cpurst_b)
    ex1_pipedown && !flush |=> ex2_srt_first_round)
    else $error("ex2_srt_first_round missing after ex1_pipedown");

  a_first_clr: assert property (@(posedge fdsu_clk) disable iff (!cpurst_b)
    !ex1_pipedown |=> !ex2_srt_first_round)
    else $error("ex2_srt_first_round without ex1_pipedown");

  // ====================================================================
  // flush
  // ====================================================================
  a_flush_quiet: assert property (@(posedge fdsu_clk) disable iff (!cpurst_b)
    flush |=> state_idle && !busy && !wb_req && !srt_sm_on && !ex2_pipedown
      && !ex3_pipedown && !ex4_pipedown && !ex2_srt_first_round && !ex1_denormal_stall)
    else $error("outputs active in the cycle after flush");

endmodule

bind fdsu_scalar_ctrl fdsu_ctrl_sva x_ctrl_sva (
  .fdsu_clk            (fdsu_clk),
  .cpurst_b            (cpurst_b),
  .flush               (flush),
  .wb_grnt             (wb_grnt),
  .wb_req              (wb_req),
  .ex1_pipedown        (ex1_pipedown),
  .ex2_pipedown        (ex2_pipedown),
  .ex3_pipedown        (ex3_pipedown),
  .ex4_pipedown        (ex4_pipedown),
  .ex2_srt_first_round (ex2_srt_first_round),
  .srt_sm_on           (srt_sm_on),
  .ex1_denormal_stall  (ex1_denormal_stall),
  .busy                (busy),
  .state_idle          (state_idle)
);

`default_nettype wire

// File: fdsu_issue_ctrl.sv
`default_nettype none

module fdsu_issue_ctrl (
  input  wire logic                  ex1_sel,
  input  wire fdsu_pkg::fdsu_fmt_t   ex1_fmt,
  input  wire logic                  ex1_div,
  input  wire logic                  op0_id_vld,
  input  wire logic                  op1_id_vld,
  input  wire fdsu_pkg::fdsu_state_e cur_state,
  output logic                       dn_op0_id,
  output logic                       dn_op1_id,
  output logic                       ex1_denormal_stall,
  output logic                       ex1_op1_sel,
  output logic                       ex1_save_ff1_op1_id,
  output logic                       ex1_save_op0,
  output logic                       ex1_save_op0_gate,
  output logic                       save_op0_neg_expnt
);

  import fdsu_pkg::*;

  logic st_idle;
  logic st_id0;
  logic st_wfi2;
  logic st_id1;
  logic fmt_vld;
  logic op0_id_raw;
  logic op1_id_raw;
  logic sm_start;

  // ====================================================================
  // state decode
  // ====================================================================
  assign st_idle = (cur_state == IDLE);
  assign st_id0  = (cur_state == ID0);
  assign st_wfi2 = (cur_state == WFI2);
  assign st_id1  = (cur_state == ID1);

  // new operation offered while idle
  assign sm_start = ex1_sel && st_idle;

  // ====================================================================
  // denormal identify needs
  // ====================================================================
  // no format bit set means no valid operand to look at
  assign fmt_vld = |ex1_fmt;

  // raw bits, before the sel/div qualification
  assign op0_id_raw = fmt_vld && op0_id_vld;
  assign op1_id_raw = fmt_vld && op1_id_vld;

  assign dn_op0_id = ex1_sel && op0_id_raw;
  // op1 only exists for divide, sqrt ignores it
  assign dn_op1_id = ex1_sel && ex1_div && op1_id_raw;

  // issuer must hold ex1 while op1 is still pending
  assign ex1_denormal_stall = ex1_sel && (st_wfi2 || (st_id0 && dn_op1_id));

  // ====================================================================
  // datapath select strobes
  // ====================================================================
  // steer op1 into the ff1 path for its identify cycles
  assign ex1_op1_sel = st_wfi2 || st_id1;

  // ff1 result of op1 captured one cycle ahead of id1
  assign ex1_save_ff1_op1_id = st_wfi2;

  // ====================================================================
  // op0 save strobes
  // ====================================================================
  // enable window for the op0 holding regs
  assign ex1_save_op0_gate = st_id0 || sm_start;

  // normalized op0 parked while op1 takes the shared path
  assign ex1_save_op0 = st_id0 && op1_id_raw;

  // exponent adjust of op0 kept for the later op1 pass
  assign save_op0_neg_expnt = st_id0 && dn_op1_id;

endmodule

`default_nettype wire

// File: fdsu_main_fsm.sv
`default_nettype none

module fdsu_main_fsm (
  input  wire logic            fdsu_clk,
  input  wire logic            cpurst_b,
  input  wire logic            flush,
  input  wire logic            ex1_sel,
  input  wire logic            dn_op0_id,
  input  wire logic            dn_op1_id,
  input  wire logic            srt_last_round,
  input  wire logic            wb_grnt,
  output fdsu_pkg::fdsu_state_e cur_state,
  output logic                 iter_start,
  output logic                 ex1_pipedown,
  output logic                 ex2_pipedown,
  output logic                 ex3_pipedown,
  output logic                 ex4_pipedown,
  output logic                 srt_sm_on,
  output logic                 busy,
  output logic                 state_idle,
  output logic                 wb_req
);

  import fdsu_pkg::*;

  fdsu_state_e next_state;
  logic        st_idle;
  logic        st_id0;
  logic        st_wfi2;
  logic        st_id1;
  logic        st_iter;
  logic        st_rnd;
  logic        st_pack;
  logic        st_wfwb;

  // ====================================================================
  // state register
  // ====================================================================
  always_ff @(posedge fdsu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_state <= IDLE;
    else if (flush)
      cur_state <= IDLE;
    else
      cur_state <= next_state;
  end

  // ====================================================================
  // next state
  // ====================================================================
  always_comb
  begin
    next_state = cur_state;
    case (cur_state)
      IDLE:
      begin
        if (ex1_sel)
        begin
          // op0 identify first, op1 after it
          if (dn_op0_id)
            next_state = ID0;
          else if (dn_op1_id)
            next_state = WFI2;
          else
            next_state = ITER;
        end
      end
      ID0:
      begin
        if (dn_op1_id)
          next_state = WFI2;
        else
          next_state = ITER;
      end
      WFI2:
        next_state = ID1;
      ID1:
        next_state = ITER;
      ITER:
      begin
        // last round already implies iter
        if (srt_last_round)
          next_state = RND;
      end
      RND:
        next_state = PACK;
      PACK:
        next_state = WFWB;
      WFWB:
      begin
        // hold the request until the result bus takes it
        if (wb_grnt)
          next_state = IDLE;
      end
      default:
        next_state = IDLE;
    endcase
  end

  // ====================================================================
  // state decode and outputs
  // ====================================================================
  assign st_idle = (cur_state == IDLE);
  assign st_id0  = (cur_state == ID0);
  assign st_wfi2 = (cur_state == WFI2);
  assign st_id1  = (cur_state == ID1);
  assign st_iter = (cur_state == ITER);
  assign st_rnd  = (cur_state == RND);
  assign st_pack = (cur_state == PACK);
  assign st_wfwb = (cur_state == WFWB);

  // leave ex1 once no identify cycle is left
  assign iter_start = (st_idle && ex1_sel && !dn_op0_id && !dn_op1_id)
                    || (st_id0 && !dn_op1_id)
                    || st_id1;

  assign ex1_pipedown = iter_start;
  assign ex2_pipedown = srt_last_round;
  assign ex3_pipedown = st_rnd;
  assign ex4_pipedown = st_pack;

  assign srt_sm_on  = st_iter;
  // the identify states still count as ex1, not busy
  assign busy       = !st_idle && !st_id0 && !st_wfi2 && !st_id1;
  assign state_idle = st_idle;
  assign wb_req     = st_wfwb;

endmodule

`default_nettype wire

// File: fdsu_pkg.sv
`default_nettype none

package fdsu_pkg;

  // ====================================================================
  // controller states
  // ====================================================================
  // id0/wfi2/id1 are the denormal identify cycles, all still in ex1
  typedef enum logic [2:0] {
    IDLE = 3'b000,
    WFI2 = 3'b001,
    ITER = 3'b010,
    RND  = 3'b011,
    PACK = 3'b100,
    WFWB = 3'b101,
    ID0  = 3'b110,
    ID1  = 3'b111
  } fdsu_state_e;

  // ====================================================================
  // operation format
  // ====================================================================
  // one-hot, double in bit 0
  typedef logic [3:0] fdsu_fmt_t;

  localparam int FMT_DOUBLE = 0;
  localparam int FMT_SINGLE = 1;
  localparam int FMT_HALF   = 2;
  localparam int FMT_BHALF  = 3;

  // ====================================================================
  // srt round counter
  // ====================================================================
  typedef logic [4:0] srt_cnt_t;

  // iter runs count + 1 rounds
  localparam srt_cnt_t DEF_CNT_DOUBLE = 5'd28;
  localparam srt_cnt_t DEF_CNT_SINGLE = 5'd13;
  localparam srt_cnt_t DEF_CNT_HALF   = 5'd7;
  localparam srt_cnt_t DEF_CNT_BHALF  = 5'd5;

endpackage

`default_nettype wire

// File: fdsu_scalar_ctrl.sv
`default_nettype none

module fdsu_scalar_ctrl #(
  parameter fdsu_pkg::srt_cnt_t CNT_INI_DOUBLE = fdsu_pkg::DEF_CNT_DOUBLE,
  parameter fdsu_pkg::srt_cnt_t CNT_INI_SINGLE = fdsu_pkg::DEF_CNT_SINGLE,
  parameter fdsu_pkg::srt_cnt_t CNT_INI_HALF   = fdsu_pkg::DEF_CNT_HALF,
  parameter fdsu_pkg::srt_cnt_t CNT_INI_BHALF  = fdsu_pkg::DEF_CNT_BHALF
) (
  input  wire logic                fdsu_clk,
  input  wire logic                cpurst_b,
  input  wire logic                flush,
  input  wire logic                ex1_sel,
  input  wire fdsu_pkg::fdsu_fmt_t ex1_fmt,
  input  wire logic                ex1_div,
  input  wire logic                op0_id_vld,
  input  wire logic                op1_id_vld,
  input  wire logic                ex1_srt_skip,
  input  wire logic                ex2_of,
  input  wire logic                ex2_uf_srt_skip,
  input  wire logic                srt_remainder_zero,
  input  wire logic                wb_grnt,
  output logic                     ex1_pipedown,
  output logic                     ex2_pipedown,
  output logic                     ex3_pipedown,
  output logic                     ex4_pipedown,
  output logic                     ex2_srt_first_round,
  output logic                     srt_sm_on,
  output logic                     ex1_op1_sel,
  output logic                     ex1_save_ff1_op1_id,
  output logic                     ex1_save_op0,
  output logic                     ex1_save_op0_gate,
  output logic                     save_op0_neg_expnt,
  output logic                     ex1_denormal_stall,
  output logic                     busy,
  output logic                     state_idle,
  output logic                     wb_req
);

  import fdsu_pkg::*;

  fdsu_state_e cur_state;
  logic        dn_op0_id;
  logic        dn_op1_id;
  logic        iter_start;
  logic        srt_last_round;

  // ====================================================================
  // issue and denormal identify
  // ====================================================================
  fdsu_issue_ctrl x_issue_ctrl (
    .ex1_sel             (ex1_sel),
    .ex1_fmt             (ex1_fmt),
    .ex1_div             (ex1_div),
    .op0_id_vld          (op0_id_vld),
    .op1_id_vld          (op1_id_vld),
    .cur_state           (cur_state),
    .dn_op0_id           (dn_op0_id),
    .dn_op1_id           (dn_op1_id),
    .ex1_denormal_stall  (ex1_denormal_stall),
    .ex1_op1_sel         (ex1_op1_sel),
    .ex1_save_ff1_op1_id (ex1_save_ff1_op1_id),
    .ex1_save_op0        (ex1_save_op0),
    .ex1_save_op0_gate   (ex1_save_op0_gate),
    .save_op0_neg_expnt  (save_op0_neg_expnt)
  );

  // ====================================================================
  // main sequencer
  // ====================================================================
  fdsu_main_fsm x_main_fsm (
    .fdsu_clk       (fdsu_clk),
    .cpurst_b       (cpurst_b),
    .flush          (flush),
    .ex1_sel        (ex1_sel),
    .dn_op0_id      (dn_op0_id),
    .dn_op1_id      (dn_op1_id),
    .srt_last_round (srt_last_round),
    .wb_grnt        (wb_grnt),
    .cur_state      (cur_state),
    .iter_start     (iter_start),
    .ex1_pipedown   (ex1_pipedown),
    .ex2_pipedown   (ex2_pipedown),
    .ex3_pipedown   (ex3_pipedown),
    .ex4_pipedown   (ex4_pipedown),
    .srt_sm_on      (srt_sm_on),
    .busy           (busy),
    .state_idle     (state_idle),
    .wb_req         (wb_req)
  );

  // ====================================================================
  // srt round counter
  // ====================================================================
  fdsu_srt_counter #(
    .CNT_INI_DOUBLE (CNT_INI_DOUBLE),
    .CNT_INI_SINGLE (CNT_INI_SINGLE),
    .CNT_INI_HALF   (CNT_INI_HALF),
    .CNT_INI_BHALF  (CNT_INI_BHALF)
  ) x_srt_counter (
    .fdsu_clk            (fdsu_clk),
    .cpurst_b            (cpurst_b),
    .flush               (flush),
    .cur_state           (cur_state),
    .iter_start          (iter_start),
    .ex1_fmt             (ex1_fmt),
    .ex1_srt_skip        (ex1_srt_skip),
    .ex2_of              (ex2_of),
    .ex2_uf_srt_skip     (ex2_uf_srt_skip),
    .srt_remainder_zero  (srt_remainder_zero),
    .srt_last_round      (srt_last_round),
    .ex2_srt_first_round (ex2_srt_first_round)
  );

endmodule

`default_nettype wire

// File: fdsu_srt_counter.sv
`default_nettype none

module fdsu_srt_counter #(
  parameter fdsu_pkg::srt_cnt_t CNT_INI_DOUBLE = fdsu_pkg::DEF_CNT_DOUBLE,
  parameter fdsu_pkg::srt_cnt_t CNT_INI_SINGLE = fdsu_pkg::DEF_CNT_SINGLE,
  parameter fdsu_pkg::srt_cnt_t CNT_INI_HALF   = fdsu_pkg::DEF_CNT_HALF,
  parameter fdsu_pkg::srt_cnt_t CNT_INI_BHALF  = fdsu_pkg::DEF_CNT_BHALF
) (
  input  wire logic                  fdsu_clk,
  input  wire logic                  cpurst_b,
  input  wire logic                  flush,
  input  wire fdsu_pkg::fdsu_state_e cur_state,
  input  wire logic                  iter_start,
  input  wire fdsu_pkg::fdsu_fmt_t   ex1_fmt,
  input  wire logic                  ex1_srt_skip,
  input  wire logic                  ex2_of,
  input  wire logic                  ex2_uf_srt_skip,
  input  wire logic                  srt_remainder_zero,
  output logic                       srt_last_round,
  output logic                       ex2_srt_first_round
);

  import fdsu_pkg::*;

  srt_cnt_t srt_cnt;
  srt_cnt_t cnt_ini;
  logic     st_iter;
  logic     cnt_zero;
  logic     ex2_special_skip;
  logic     any_skip;

  assign st_iter = (cur_state == ITER);

  // ====================================================================
  // round counter
  // ====================================================================
  // format is one-hot, so the or-tree picks exactly one count
  assign cnt_ini = ({$bits(srt_cnt_t){ex1_fmt[FMT_DOUBLE]}} & CNT_INI_DOUBLE)
                 | ({$bits(srt_cnt_t){ex1_fmt[FMT_SINGLE]}} & CNT_INI_SINGLE)
                 | ({$bits(srt_cnt_t){ex1_fmt[FMT_HALF]}}   & CNT_INI_HALF)
                 | ({$bits(srt_cnt_t){ex1_fmt[FMT_BHALF]}}  & CNT_INI_BHALF);

  always_ff @(posedge fdsu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      srt_cnt <= '0;
    else if (flush)
      srt_cnt <= '0;
    else if (iter_start)
      srt_cnt <= cnt_ini;
    else if (st_iter)
      srt_cnt <= srt_cnt - srt_cnt_t'(1);
  end

  assign cnt_zero = (srt_cnt == '0);

  // ====================================================================
  // special skip and first round
  // ====================================================================
  // issue-time special case, held through iter
  always_ff @(posedge fdsu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex2_special_skip <= 1'b0;
    else if (iter_start)
      ex2_special_skip <= ex1_srt_skip;
  end

  // one cycle after ex1 pipedown
  always_ff @(posedge fdsu_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex2_srt_first_round <= 1'b0;
    else if (flush)
      ex2_srt_first_round <= 1'b0;
    else
      ex2_srt_first_round <= iter_start;
  end

  // ====================================================================
  // last round
  // ====================================================================
  assign any_skip = ex2_special_skip || ex2_of || ex2_uf_srt_skip;

  // early end or count exhausted, only meaningful in iter
  assign srt_last_round = st_iter && (cnt_zero || any_skip || srt_remainder_zero);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the controller testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f tb.f --top-module tb_fdsu_scalar_ctrl \
    -o sim_fdsu > build.log 2>&1 \
  && ./obj_dir/sim_fdsu > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation returned an error"; }

cat sim.log 2>/dev/null

# result decided from the simulation log
grep -qx "Simulation passed" sim.log 2>/dev/null && exit 0 || exit 1

// File: tb.f
fdsu_pkg.sv
fdsu_issue_ctrl.sv
fdsu_main_fsm.sv
fdsu_srt_counter.sv
fdsu_scalar_ctrl.sv
fdsu_ctrl_sva.sv
tb_fdsu_scalar_ctrl.sv

// File: tb_fdsu_scalar_ctrl.sv
`default_nettype none

module tb_fdsu_scalar_ctrl;

  import fdsu_pkg::*;

  logic        fdsu_clk;
  logic        cpurst_b;
  logic        flush;
  logic        ex1_sel;
  fdsu_fmt_t   ex1_fmt;
  logic        ex1_div;
  logic        op0_id_vld;
  logic        op1_id_vld;
  logic        ex1_srt_skip;
  logic        ex2_of;
  logic        ex2_uf_srt_skip;
  logic        srt_remainder_zero;
  logic        wb_grnt;
  logic        ex1_pipedown;
  logic        ex2_pipedown;
  logic        ex3_pipedown;
  logic        ex4_pipedown;
  logic        ex2_srt_first_round;
  logic        srt_sm_on;
  logic        ex1_op1_sel;
  logic        ex1_save_ff1_op1_id;
  logic        ex1_save_op0;
  logic        ex1_save_op0_gate;
  logic        save_op0_neg_expnt;
  logic        ex1_denormal_stall;
  logic        busy;
  logic        state_idle;
  logic        wb_req;

  // reference model, current and next
  fdsu_state_e m_state;
  fdsu_state_e m_next;
  logic [4:0]  m_cnt;
  logic [4:0]  m_cnt_next;
  logic        m_skip;
  logic        m_skip_next;
  logic        m_first;
  logic        m_first_next;

  logic [31:0] rng;
  int          errors;
  int          timeouts;
  int          cycle;
  logic        aborted;

  fdsu_scalar_ctrl dut (.*);

  initial
  begin
    fdsu_clk = 1'b0;
    forever #2 fdsu_clk = ~fdsu_clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // initial round count per one-hot format
  function automatic logic [4:0] round_count(input fdsu_fmt_t fmt);
    case (fmt)
      4'b0001: return 5'd28;
      4'b0010: return 5'd13;
      4'b0100: return 5'd7;
      4'b1000: return 5'd5;
      default: return 5'd0;
    endcase
  endfunction

  task automatic drive_quiet();
    flush              = 1'b0;
    ex1_sel            = 1'b0;
    ex1_fmt            = 4'b0000;
    ex1_div            = 1'b0;
    op0_id_vld         = 1'b0;
    op1_id_vld         = 1'b0;
    ex1_srt_skip       = 1'b0;
    ex2_of             = 1'b0;
    ex2_uf_srt_skip    = 1'b0;
    srt_remainder_zero = 1'b0;
    wb_grnt            = 1'b0;
  endtask

  task automatic compare(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s: got %h expected %h (cycle %0d)", name, got, exp, cycle);
    end
  endtask

  // clock edge, model update, then the drive point
  task automatic advance();
    @(posedge fdsu_clk);
    m_state = m_next;
    m_cnt   = m_cnt_next;
    m_skip  = m_skip_next;
    m_first = m_first_next;
    cycle++;
    #1;
  endtask

  // ====================================================================
  // per-cycle check against the model
  // ====================================================================
  task automatic check_cycle();
    logic fmt_ok;
    logic need0;
    logic need1;
    logic raw1;
    logic e_last;
    logic e_start;
    #2;
    fmt_ok  = (ex1_fmt != 4'b0000);
    need0   = ex1_sel && fmt_ok && op0_id_vld;
    raw1    = fmt_ok && op1_id_vld;
    // sqrt has no op1
    need1   = ex1_sel && ex1_div && raw1;
    e_last  = (m_state == ITER) && ((m_cnt == 5'd0) || m_skip || ex2_of
              || ex2_uf_srt_skip || srt_remainder_zero);
    e_start = ((m_state == IDLE) && ex1_sel && !need0 && !need1)
              || ((m_state == ID0) && !need1) || (m_state == ID1);

    compare("ex1_pipedown", ex1_pipedown, e_start);
    compare("ex2_pipedown", ex2_pipedown, e_last);
    compare("ex3_pipedown", ex3_pipedown, m_state == RND);
    compare("ex4_pipedown", ex4_pipedown, m_state == PACK);
    compare("ex2_srt_first_round", ex2_srt_first_round, m_first);
    compare("srt_sm_on", srt_sm_on, m_state == ITER);
    compare("ex1_op1_sel", ex1_op1_sel, (m_state == WFI2) || (m_state == ID1));
    compare("ex1_save_ff1_op1_id", ex1_save_ff1_op1_id, m_state == WFI2);
    compare("ex1_save_op0", ex1_save_op0, (m_state == ID0) && raw1);
    compare("ex1_save_op0_gate", ex1_save_op0_gate,
            (m_state == ID0) || ((m_state == IDLE) && ex1_sel));
    compare("save_op0_neg_expnt", save_op0_neg_expnt, (m_state == ID0) && need1);
    compare("ex1_denormal_stall", ex1_denormal_stall,
            ex1_sel && ((m_state == WFI2) || ((m_state == ID0) && need1)));
    compare("busy", busy, !(m_state inside {IDLE, ID0, WFI2, ID1}));
    compare("state_idle", state_idle, m_state == IDLE);
    compare("wb_req", wb_req, m_state == WFWB);

    // next model state
    case (m_state)
      IDLE:    m_next = !ex1_sel ? IDLE : (need0 ? ID0 : (need1 ? WFI2 : ITER));
      ID0:     m_next = need1 ? WFI2 : ITER;
      WFI2:    m_next = ID1;
      ID1:     m_next = ITER;
      ITER:    m_next = e_last ? RND : ITER;
      RND:     m_next = PACK;
      PACK:    m_next = WFWB;
      WFWB:    m_next = wb_grnt ? IDLE : WFWB;
      default: m_next = IDLE;
    endcase
    if (flush)
      m_next = IDLE;

    if (flush)
      m_cnt_next = 5'd0;
    else if (e_start)
      m_cnt_next = round_count(ex1_fmt);
    else if (m_state == ITER)
      m_cnt_next = m_cnt - 5'd1;
    else
      m_cnt_next = m_cnt;

    // issue skip captured at start, flush leaves it
    m_skip_next  = e_start ? ex1_srt_skip : m_skip;
    m_first_next = !flush && e_start;
  endtask

  // ====================================================================
  // one operation from issue to write-back or flush
  // ====================================================================
  task automatic run_op(input int fmt_sel, input logic plain);
    fdsu_fmt_t  fmt;
    logic       div;
    logic       id0;
    logic       id1;
    logic       skip;
    logic [1:0] kind;
    logic [4:0] early_at;
    logic [4:0] iter_n;
    logic [2:0] grant_dly;
    logic [2:0] wb_n;
    logic       do_flush;
    logic       flushed;
    logic       accepted;
    logic       done;
    logic       early;
    int         flush_at;
    int         n;
    int         t_sel;
    int         t1;
    int         t2;
    int         tw;
    int         ids;
    rng = xorshift(rng);
    if (fmt_sel < 0)
      fmt = 4'b0001 << rng[1:0];
    else
      fmt = 4'b0001 << fmt_sel[1:0];
    div       = rng[2];
    id0       = !plain && rng[3];
    id1       = !plain && rng[4];
    skip      = !plain && (rng[7:5] == 3'd0);
    // kind 3 means no early end input
    kind      = plain ? 2'd3 : rng[9:8];
    early_at  = rng[14:10];
    grant_dly = rng[17:15];
    do_flush  = !plain && (rng[19:18] == 2'd0);
    flush_at  = int'(rng[25:20]);
    accepted  = 1'b0;
    flushed   = 1'b0;
    done      = 1'b0;
    iter_n    = 5'd0;
    wb_n      = 3'd0;
    t_sel     = 0;
    t1        = -1;
    t2        = -1;
    tw        = -1;

    for (n = 0; n < 200 && !done; n++)
    begin
      advance();
      rng = xorshift(rng);
      if (n == 0)
        t_sel = cycle;
      // issuer holds sel until ex1 pipedown
      ex1_sel      = !accepted;
      ex1_fmt      = fmt;
      ex1_div      = div;
      op0_id_vld   = id0;
      op1_id_vld   = id1;
      ex1_srt_skip = skip;
      if (m_state == ITER)
      begin
        ex2_of             = (kind == 2'd0) && (iter_n == early_at);
        ex2_uf_srt_skip    = (kind == 2'd1) && (iter_n == early_at);
        srt_remainder_zero = (kind == 2'd2) && (iter_n == early_at);
        iter_n = iter_n + 5'd1;
      end
      else
      begin
        // noise, must be ignored outside iter
        ex2_of             = rng[0];
        ex2_uf_srt_skip    = rng[1];
        srt_remainder_zero = rng[2];
      end
      if (m_state == WFWB)
      begin
        wb_grnt = (wb_n == grant_dly);
        wb_n = wb_n + 3'd1;
      end
      else
        wb_grnt = rng[3];
      flush = do_flush && (n == flush_at);
      check_cycle();
      if (ex1_pipedown && t1 < 0)
        t1 = cycle;
      if (ex2_pipedown && t2 < 0)
        t2 = cycle;
      if (wb_req && tw < 0)
        tw = cycle;
      accepted = accepted || ex1_pipedown;
      flushed  = flushed || flush;
      if (flush || ((m_state == WFWB) && wb_grnt))
        done = 1'b1;
    end

    if (!done)
    begin
      timeouts++;
      aborted = 1'b1;
      $display("timeout: operation did not finish within 200 cycles");
    end
    else if (flushed)
    begin
      // quiet cycle right after flush
      advance();
      drive_quiet();
      check_cycle();
      if (!state_idle || busy || wb_req || srt_sm_on || ex1_denormal_stall)
      begin
        errors++;
        $display("controller not idle in the cycle after flush (cycle %0d)", cycle);
      end
    end
    else
    begin
      ids   = (id0 ? 1 : 0) + ((id1 && div) ? 2 : 0);
      early = skip || ((kind != 2'd3) && (early_at <= round_count(fmt)));
      if (t1 - t_sel != ids)
      begin
        errors++;
        $display("MISMATCH ex1_pipedown delay: got %h expected %h", t1 - t_sel, ids);
      end
      // rnd and pack sit between the last round and write-back
      if (tw - t2 != 3)
      begin
        errors++;
        $display("MISMATCH wb_req after ex2_pipedown: got %h expected %h", tw - t2, 3);
      end
      if (!early && (tw - t1 != int'(round_count(fmt)) + 4))
      begin
        errors++;
        $display("MISMATCH wb_req after ex1_pipedown: got %h expected %h",
                 tw - t1, int'(round_count(fmt)) + 4);
      end
    end
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================
  initial
  begin
    int i;
    rng          = 32'h60ff;
    errors       = 0;
    timeouts     = 0;
    cycle        = 0;
    aborted      = 1'b0;
    m_state      = IDLE;
    m_next       = IDLE;
    m_cnt        = 5'd0;
    m_cnt_next   = 5'd0;
    m_skip       = 1'b0;
    m_skip_next  = 1'b0;
    m_first      = 1'b0;
    m_first_next = 1'b0;
    cpurst_b     = 1'b0;
    drive_quiet();

    repeat (2) @(posedge fdsu_clk);
    #1;
    cpurst_b = 1'b1;
    check_cycle();

    // each format once, no identify and no early end
    for (i = 0; i < 4 && !aborted; i++)
      run_op(i, 1'b1);
    // random mix with denormals, early ends, back-pressure and flush
    for (i = 0; i < 160 && !aborted; i++)
      run_op(-1, 1'b0);

    $display("closing: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
